//--- list.f
rtl/ooo_pkg.sv
rtl/issue_stage.sv
rtl/alu_unit.sv
rtl/mult_unit.sv
rtl/cdb_arbiter.sv
rtl/reorder_buffer.sv
rtl/ooo_core.sv
verif/ooo_core_tb.sv

//--- rtl/alu_unit.sv
/*
 * Single-cycle ALU with its execute/writeback holding register.
 * The result waits there until the CDB arbiter grants it.
 */
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
	input  wire logic                               clock,
	input  wire logic                               reset,
	input  wire logic                               start,
	input  wire ooo_pkg::issue_packet_t             operands,
	input  wire logic [ooo_pkg::ROB_TAG_LEN-1:0]    tag,
	input  wire logic                               written,
	output ooo_pkg::wr_packet_t                     result,
	output logic                                    busy
);
	import ooo_pkg::*;

	logic [XLEN-1:0] alu_value;
	wr_packet_t hold_q;

	// all ops wrap modulo 2^XLEN
	always_comb begin
		case (operands.op)
			OP_ADD: alu_value = operands.rs1_value + operands.rs2_value;
			OP_SUB: alu_value = operands.rs1_value - operands.rs2_value;
			OP_AND: alu_value = operands.rs1_value & operands.rs2_value;
			OP_OR:  alu_value = operands.rs1_value | operands.rs2_value;
			OP_XOR: alu_value = operands.rs1_value ^ operands.rs2_value;
			// multiply never gets steered here
			default: alu_value = '0;
		endcase
	end

	////////////////////////////////////////
	// holding register
	////////////////////////////////////////

	// valid bit is control, tag and value just follow a load
	always_ff @(posedge clock) begin
		if (reset) begin
			hold_q.valid <= 1'b0;
		end else if (start) begin
			hold_q.valid <= 1'b1;
		end else if (written) begin
			hold_q.valid <= 1'b0;
		end
		if (start) begin
			hold_q.rob_tag <= tag;
			hold_q.value <= alu_value;
		end
	end

	assign result = hold_q;

	// full unless the CDB drains it this cycle
	assign busy = hold_q.valid & ~written;

	// issue stage must hold back while the register is occupied
	assert property (@(posedge clock) disable iff (reset) start |-> !busy)
		else $error("alu_unit: start while busy");

endmodule

`default_nettype wire

//--- rtl/cdb_arbiter.sv
/*
 * Fixed-priority grant of the common data bus, multiplier before ALU.
 * The written pulse tells the winning unit to drop its holding register.
 */
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
	input  wire ooo_pkg::wr_packet_t alu_result,
	input  wire ooo_pkg::wr_packet_t mult_result,
	output ooo_pkg::wr_packet_t      cdb,
	output logic                     alu_written,
	output logic                     mult_written
);

	always_comb begin
		// idle bus by default
		cdb = '0;
		alu_written = 1'b0;
		mult_written = 1'b0;

		// multiplier first, its whole pipeline stalls behind a loser
		if (mult_result.valid) begin
			cdb = mult_result;
			mult_written = 1'b1;
		end else if (alu_result.valid) begin
			cdb = alu_result;
			alu_written = 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/issue_stage.sv
/*
 * Hazard check and steering for the issue strobe.
 * Accepts an instruction only when the ROB has room and its unit is free.
 */
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
	input  wire logic         issue_valid,
	input  wire ooo_pkg::op_e issue_op,
	input  wire logic         rob_full,
	input  wire logic         alu_busy,
	input  wire logic         mult_busy,
	output logic              issue_stall,
	output logic              rob_alloc,
	output logic              alu_start,
	output logic              mult_start
);
	import ooo_pkg::*;

	logic is_mult;
	logic unit_busy;
	logic accept;

	always_comb begin
		// route by opcode, everything but multiply is an ALU op
		is_mult = (issue_op == OP_MUL);
		unit_busy = is_mult ? mult_busy : alu_busy;

		// stall only matters while something is offered
		issue_stall = issue_valid & (rob_full | unit_busy);
		accept = issue_valid & ~issue_stall;

		// tag allocation and unit start in the same cycle
		rob_alloc = accept;
		alu_start = accept & ~is_mult;
		mult_start = accept & is_mult;
	end

endmodule

`default_nettype wire

//--- rtl/mult_unit.sv
/*
 * Pipelined multiplier, MULT_STAGES deep, low XLEN bits of the product.
 * The last stage is the holding register; the whole chain freezes behind it.
 */
`timescale 1ns/1ps
`default_nettype none

module mult_unit (
	input  wire logic                               clock,
	input  wire logic                               reset,
	input  wire logic                               start,
	input  wire ooo_pkg::issue_packet_t             operands,
	input  wire logic [ooo_pkg::ROB_TAG_LEN-1:0]    tag,
	input  wire logic                               written,
	output ooo_pkg::wr_packet_t                     result,
	output logic                                    busy
);
	import ooo_pkg::*;

	// index of the output stage
	localparam int LAST = MULT_STAGES - 1;

	logic [MULT_STAGES-1:0] stage_valid;
	logic [ROB_TAG_LEN-1:0] stage_tag [MULT_STAGES];
	logic [XLEN-1:0] stage_value [MULT_STAGES];
	logic [XLEN-1:0] product;
	logic advance;

	// low half only, upper bits are dropped by the assignment width
	// synthesis can retime this across the following stages
	assign product = operands.rs1_value * operands.rs2_value;

	////////////////////////////////////////
	// stall control
	////////////////////////////////////////

	// output stage stuck waiting for the CDB
	assign busy = stage_valid[LAST] & ~written;

	// everything moves together or not at all
	assign advance = ~busy;

	////////////////////////////////////////
	// pipeline stages
	////////////////////////////////////////

	// valid chain, bubbles shift through like entries
	always_ff @(posedge clock) begin
		if (reset) begin
			stage_valid <= '0;
		end else if (advance) begin
			stage_valid <= {stage_valid[LAST-1:0], start};
		end
	end

	// tag and value ride along with their valid bit
	always_ff @(posedge clock) begin
		if (advance) begin
			stage_tag[0] <= tag;
			stage_value[0] <= product;
			for (int i = 1; i < MULT_STAGES; i++) begin
				stage_tag[i] <= stage_tag[i-1];
				stage_value[i] <= stage_value[i-1];
			end
		end
	end

	// last stage doubles as the holding register
	assign result = '{
		valid:   stage_valid[LAST],
		rob_tag: stage_tag[LAST],
		value:   stage_value[LAST]
	};

	// issue stage sees mult_busy and must not start into a frozen chain
	assert property (@(posedge clock) disable iff (reset) start |-> !busy)
		else $error("mult_unit: start while busy");

endmodule

`default_nettype wire

//--- rtl/ooo_core.sv
/*
 * Top of the out-of-order back end: issue stage, ALU, multiplier,
 * CDB arbiter and reorder buffer wired together.
 */
`timescale 1ns/1ps
`default_nettype none

module ooo_core (
	input  wire logic                   clock,
	input  wire logic                   reset,
	input  wire logic                   issue_valid,
	input  wire ooo_pkg::issue_packet_t issue,
	output logic                        issue_stall,
	output ooo_pkg::commit_packet_t     commit
);
	import ooo_pkg::*;

	// issue side
	logic rob_alloc;
	logic rob_full;
	logic [ROB_TAG_LEN-1:0] alloc_tag;
	logic alu_start;
	logic mult_start;

	// unit back-pressure
	logic alu_busy;
	logic mult_busy;

	// writeback side
	wr_packet_t alu_result;
	wr_packet_t mult_result;
	wr_packet_t cdb;
	logic alu_written;
	logic mult_written;

	issue_stage u_issue_stage (
		.issue_valid (issue_valid),
		.issue_op    (issue.op),
		.rob_full    (rob_full),
		.alu_busy    (alu_busy),
		.mult_busy   (mult_busy),
		.issue_stall (issue_stall),
		.rob_alloc   (rob_alloc),
		.alu_start   (alu_start),
		.mult_start  (mult_start)
	);

	// both units get the same operands and tag, start picks one
	alu_unit u_alu_unit (
		.clock    (clock),
		.reset    (reset),
		.start    (alu_start),
		.operands (issue),
		.tag      (alloc_tag),
		.written  (alu_written),
		.result   (alu_result),
		.busy     (alu_busy)
	);

	mult_unit u_mult_unit (
		.clock    (clock),
		.reset    (reset),
		.start    (mult_start),
		.operands (issue),
		.tag      (alloc_tag),
		.written  (mult_written),
		.result   (mult_result),
		.busy     (mult_busy)
	);

	cdb_arbiter u_cdb_arbiter (
		.alu_result   (alu_result),
		.mult_result  (mult_result),
		.cdb          (cdb),
		.alu_written  (alu_written),
		.mult_written (mult_written)
	);

	reorder_buffer u_reorder_buffer (
		.clock      (clock),
		.reset      (reset),
		.alloc      (rob_alloc),
		.alloc_dest (issue.dest_reg),
		.cdb        (cdb),
		.alloc_tag  (alloc_tag),
		.full       (rob_full),
		.commit     (commit)
	);

endmodule

`default_nettype wire

//--- rtl/ooo_pkg.sv
/*
 * Shared widths, depths, opcodes and packet types for the out-of-order back end.
 * Modules name these types in their ports and import the package in their bodies.
 */
`default_nettype none

package ooo_pkg;

	////////////////////////////////////////
	// widths and depths
	////////////////////////////////////////

	// data path width
	localparam int XLEN = 32;

	// reorder buffer size, tag width follows from it
	localparam int ROB_DEPTH = 8;
	localparam int ROB_TAG_LEN = $clog2(ROB_DEPTH);

	// architectural destination index
	localparam int REG_IDX_LEN = 5;

	// multiplier latency in cycles
	localparam int MULT_STAGES = 4;

	////////////////////////////////////////
	// opcodes
	////////////////////////////////////////

	// OP_MUL goes to the multiplier, the rest to the ALU
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_AND = 3'd2,
		OP_OR  = 3'd3,
		OP_XOR = 3'd4,
		OP_MUL = 3'd5
	} op_e;

	////////////////////////////////////////
	// packets
	////////////////////////////////////////

	// instruction with resolved operands, 72 bits
	typedef struct packed {
		op_e                    op;
		logic [XLEN-1:0]        rs1_value;
		logic [XLEN-1:0]        rs2_value;
		logic [REG_IDX_LEN-1:0] dest_reg;
	} issue_packet_t;

	// finished result, both in the holding registers and on the CDB
	typedef struct packed {
		logic                   valid;
		logic [ROB_TAG_LEN-1:0] rob_tag;
		logic [XLEN-1:0]        value;
	} wr_packet_t;

	// retired instruction, one per cycle at most
	typedef struct packed {
		logic                   valid;
		logic [ROB_TAG_LEN-1:0] rob_tag;
		logic [REG_IDX_LEN-1:0] dest_reg;
		logic [XLEN-1:0]        value;
	} commit_packet_t;

endpackage

`default_nettype wire

//--- rtl/reorder_buffer.sv
/*
 * Circular reorder buffer: hands out tags at the tail, completes entries
 * from the CDB and retires the head in order into a registered commit packet.
 */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
	input  wire logic                               clock,
	input  wire logic                               reset,
	input  wire logic                               alloc,
	input  wire logic [ooo_pkg::REG_IDX_LEN-1:0]    alloc_dest,
	input  wire ooo_pkg::wr_packet_t                cdb,
	output logic [ooo_pkg::ROB_TAG_LEN-1:0]         alloc_tag,
	output logic                                    full,
	output ooo_pkg::commit_packet_t                 commit
);
	import ooo_pkg::*;

	logic [ROB_TAG_LEN-1:0] head;
	logic [ROB_TAG_LEN-1:0] tail;
	// one extra bit so a full buffer is distinct from an empty one
	logic [ROB_TAG_LEN:0] count;

	// per-entry state
	logic [ROB_DEPTH-1:0] entry_busy;
	logic [ROB_DEPTH-1:0] entry_done;
	logic [REG_IDX_LEN-1:0] entry_dest [ROB_DEPTH];
	logic [XLEN-1:0] entry_value [ROB_DEPTH];

	logic retire;

	// wrap at ROB_DEPTH even when it is not a power of two
	function automatic logic [ROB_TAG_LEN-1:0] next_ptr(input logic [ROB_TAG_LEN-1:0] ptr);
		if (ptr == ROB_TAG_LEN'(ROB_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// tail is the next free slot
	assign alloc_tag = tail;

	// from the registered count, so a retire frees space one cycle late
	assign full = (count == (ROB_TAG_LEN + 1)'(ROB_DEPTH));

	// head finished on an earlier edge
	assign retire = entry_busy[head] & entry_done[head];

	////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (retire) begin
				head <= next_ptr(head);
			end
			if (alloc) begin
				tail <= next_ptr(tail);
			end
			case ({alloc, retire})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////////////////////////
	// entry state
	////////////////////////////////////////

	// retire, alloc and CDB never touch the same slot in one cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			entry_busy <= '0;
			entry_done <= '0;
		end else begin
			if (retire) begin
				entry_busy[head] <= 1'b0;
			end
			if (alloc) begin
				entry_busy[tail] <= 1'b1;
				entry_done[tail] <= 1'b0;
			end
			if (cdb.valid) begin
				entry_done[cdb.rob_tag] <= 1'b1;
			end
		end
	end

	// destination at allocation, value from the bus
	always_ff @(posedge clock) begin
		if (alloc) begin
			entry_dest[tail] <= alloc_dest;
		end
		if (cdb.valid) begin
			entry_value[cdb.rob_tag] <= cdb.value;
		end
	end

	////////////////////////////////////////
	// commit
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			commit.valid <= 1'b0;
		end else begin
			commit.valid <= retire;
		end
		// payload is only meaningful with valid
		commit.rob_tag <= head;
		commit.dest_reg <= entry_dest[head];
		commit.value <= entry_value[head];
	end

	// issue stage is supposed to stall on full
	assert property (@(posedge clock) disable iff (reset) alloc |-> !full)
		else $error("reorder_buffer: alloc while full");

	// units only broadcast tags that are live and still pending
	assert property (@(posedge clock) disable iff (reset)
		cdb.valid |-> entry_busy[cdb.rob_tag] && !entry_done[cdb.rob_tag])
		else $error("reorder_buffer: CDB write to a stale entry");

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the ooo_core testbench with Verilator.
# The exit status is the simulation's: nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f list.f --top-module ooo_core_tb -o sim_ooo_core \
	&& ./obj_dir/sim_ooo_core \
	|| { echo "build or simulation returned an error"; exit 1; }

//--- verif/ooo_core_tb.sv
/*
 * Table-driven testbench for the out-of-order back end.
 * Issues a fixed instruction table, then checks every in-order commit against the table.
 */
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb;
	import ooo_pkg::*;

	localparam int NUM_ENTRIES = 24;
	localparam int CYCLE_LIMIT = NUM_ENTRIES * (MULT_STAGES + ROB_DEPTH) + 100;

	logic clock;
	logic reset;
	logic issue_valid;
	issue_packet_t issue;
	logic issue_stall;
	commit_packet_t commit;

	// stimulus table and expected commits, same index
	issue_packet_t stim_pkt [NUM_ENTRIES];
	commit_packet_t stim_exp [NUM_ENTRIES];
	op_e op_list [NUM_ENTRIES];

	int commit_count;
	int cycle_count;
	logic stall_seen;

	ooo_core u_ooo_core (
		.clock       (clock),
		.reset       (reset),
		.issue_valid (issue_valid),
		.issue       (issue),
		.issue_stall (issue_stall),
		.commit      (commit)
	);

	// 20 ns period
	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	////////////////////////////////////////
	// reference rule and checks
	////////////////////////////////////////

	// wraps modulo 2^XLEN, multiply keeps the low half
	function automatic logic [XLEN-1:0] expected_value(op_e op, logic [XLEN-1:0] a,
			logic [XLEN-1:0] b);
		logic [2*XLEN-1:0] wide;
		wide = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
		case (op)
			OP_ADD: return a + b;
			OP_SUB: return a - b;
			OP_AND: return a & b;
			OP_OR:  return a | b;
			OP_XOR: return a ^ b;
			OP_MUL: return wide[XLEN-1:0];
			default: return '0;
		endcase
	endfunction

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "run aborted at %0t", $time);
	endtask

	task automatic check_commit(commit_packet_t exp, commit_packet_t act);
		if (act !== exp) begin
			$display("[ERROR] %0t commit expected valid=%0b tag=%0d dest=%0d value=%h",
				$time, exp.valid, exp.rob_tag, exp.dest_reg, exp.value);
			$display("[ERROR] %0t commit actual   valid=%0b tag=%0d dest=%0d value=%h",
				$time, act.valid, act.rob_tag, act.dest_reg, act.value);
			abort_run();
		end
	endtask

	task automatic check_level(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
			abort_run();
		end
	endtask

	// alu ops, a mul then faster alu ops, a mul run, then a mixed tail
	task automatic build_table();
		op_list = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_MUL, OP_ADD, OP_SUB,
			OP_XOR, OP_MUL, OP_MUL, OP_MUL, OP_MUL, OP_ADD, OP_OR, OP_AND,
			OP_ADD, OP_SUB, OP_XOR, OP_OR, OP_ADD, OP_MUL, OP_AND, OP_SUB};
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			stim_pkt[i].op = op_list[i];
			stim_pkt[i].rs1_value = $urandom;
			stim_pkt[i].rs2_value = $urandom;
			stim_pkt[i].dest_reg = REG_IDX_LEN'($urandom);
			stim_exp[i].valid = 1'b1;
			// tags are handed out in order from zero and wrap
			stim_exp[i].rob_tag = ROB_TAG_LEN'(i % ROB_DEPTH);
			stim_exp[i].dest_reg = stim_pkt[i].dest_reg;
			stim_exp[i].value = expected_value(stim_pkt[i].op,
				stim_pkt[i].rs1_value, stim_pkt[i].rs2_value);
		end
	endtask

	////////////////////////////////////////
	// monitors
	////////////////////////////////////////

	// commits sampled mid-cycle, walked in table order
	always @(negedge clock) begin
		if (!reset && commit.valid === 1'b1) begin
			if (commit_count >= NUM_ENTRIES) begin
				$display("a commit arrived after every table entry had already retired");
				abort_run();
			end else begin
				check_commit(stim_exp[commit_count], commit);
				commit_count <= commit_count + 1;
			end
		end
	end

	// hang guard
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: only %0d of %0d entries committed", commit_count, NUM_ENTRIES);
			abort_run();
		end
	end

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		reset = 1'b1;
		issue_valid = 1'b0;
		issue = '0;
		commit_count = 0;
		cycle_count = 0;
		stall_seen = 1'b0;
		void'($urandom(73));
		build_table();

		// first entry offered through reset, stall and commit stay low
		// release on the eighth edge, the entry goes in on the next one
		for (int c = 0; c < 8; c++) begin
			@(posedge clock);
			if (c == 0) begin
				issue_valid <= 1'b1;
				issue <= stim_pkt[0];
			end
			if (c == 7) begin
				reset <= 1'b0;
			end
			@(negedge clock);
			check_level("commit.valid", 1'b0, commit.valid);
			check_level("issue_stall", 1'b0, issue_stall);
		end

		// back to back, each entry held while stalled
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			while (issue_stall) begin
				stall_seen = 1'b1;
				@(negedge clock);
			end
			// accepted at this edge
			@(posedge clock);
			if (i < NUM_ENTRIES - 1) begin
				issue <= stim_pkt[i + 1];
			end else begin
				issue_valid <= 1'b0;
			end
			@(negedge clock);
		end

		while (commit_count < NUM_ENTRIES) begin
			@(negedge clock);
		end
		// room for a repeated commit to show up
		repeat (2 * ROB_DEPTH) @(negedge clock);

		if (!stall_seen) begin
			$display("issue_stall never rose during the burst and the multiply run");
			abort_run();
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
